// ==== logic/pm_defs.svh ====
// P-M timing and bus widths
`ifndef PM_DEFS_SVH
`define PM_DEFS_SVH

// end-of-cycle phase length in clocks
`define PM_KC_TICKS 3

// start-of-cycle phase length in clocks
`define PM_PC_TICKS 2

// APB word address width, covers the six registers and two spare slots
`define PM_APB_AW 3

`endif

// ==== logic/pm_pkg.sv ====
// P-M shared types
`default_nettype none

package pm_pkg;

	// kind of machine cycle in progress
	typedef enum logic [1:0] {
		fetch     = 2'd0,
		step      = 2'd1,
		interrupt = 2'd2
	} cycle_kind_t;

	// sequencer phase, pc opens a cycle and kc closes it
	typedef enum logic [1:0] {
		idle = 2'd0,
		kc   = 2'd1,
		pc   = 2'd2
	} phase_t;

	// instruction and bus data word
	typedef logic [15:0] word_t;

	// group counter
	typedef logic [1:0] lg_t;

	// step counter
	typedef logic [3:0] lk_t;

	// wrapping event counter
	typedef logic [15:0] cnt_t;

endpackage

`default_nettype wire

// ==== logic/pm_cycle_if.sv ====
// P-M cycle event bundle
`timescale 1ns/1ps
`default_nettype none

interface pm_cycle_if;

	logic cyc_start;
	logic cyc_end;
	pm_pkg::cycle_kind_t kind;
	pm_pkg::word_t ir;
	// step counter still nonzero
	logic more;

	modport seq (
		output cyc_start, cyc_end, kind,
		input more
	);

	modport cnt (
		input cyc_start, cyc_end, kind, ir,
		output more
	);

	modport mon (
		output ir,
		input cyc_start, cyc_end, kind, more
	);

endinterface

`default_nettype wire

// ==== logic/pm_cycle.sv ====
// P-M cycle sequencer
`timescale 1ns/1ps
`default_nettype none
`include "pm_defs.svh"

module pm_cycle (
	input wire __clk,
	input wire rst_n,
	input wire irq,
	input wire cmd_start,
	input wire cmd_stop,
	input wire cmd_halt,
	output logic run,
	output logic wait_st,
	output logic stop_pend,
	output logic irq_ack,
	pm_cycle_if.seq cyc
);

	localparam int TICK_MAX = (`PM_KC_TICKS > `PM_PC_TICKS) ? `PM_KC_TICKS : `PM_PC_TICKS;
	localparam int TW = $clog2(TICK_MAX + 1);
	localparam int CYC_LEN = `PM_KC_TICKS + `PM_PC_TICKS;
	localparam logic [TW-1:0] PC_LAST = TW'(`PM_PC_TICKS - 1);
	localparam logic [TW-1:0] KC_LAST = TW'(`PM_KC_TICKS - 1);

	logic start_ff;
	logic wait_ff;
	logic stop_ff;
	logic halt_ff;
	logic stop_req;
	logic halt_req;
	logic [TW-1:0] tick;
	pm_pkg::phase_t phase;
	pm_pkg::cycle_kind_t kind_q;

	// requests arriving in the cyc_end clock count as well
	assign stop_req = stop_ff | cmd_stop | cmd_halt;
	assign halt_req = halt_ff | cmd_halt;

	assign cyc.cyc_start = (phase == pm_pkg::pc) && (tick == '0);
	assign cyc.cyc_end = (phase == pm_pkg::kc) && (tick == KC_LAST);
	assign cyc.kind = kind_q;

	assign run = start_ff & ~wait_ff;
	assign wait_st = wait_ff;
	assign stop_pend = stop_ff;
	assign irq_ack = cyc.cyc_start && (kind_q == pm_pkg::interrupt);

	always_ff @(posedge __clk or negedge rst_n) begin
		if (!rst_n) begin
			start_ff <= 1'b0;
			wait_ff <= 1'b0;
			stop_ff <= 1'b0;
			halt_ff <= 1'b0;
			phase <= pm_pkg::idle;
			tick <= '0;
			kind_q <= pm_pkg::fetch;
		end else begin
			// latch stop/halt while a cycle runs
			if (phase != pm_pkg::idle) begin
				if (cmd_stop || cmd_halt)
					stop_ff <= 1'b1;
				if (cmd_halt)
					halt_ff <= 1'b1;
			end
			case (phase)
				pm_pkg::idle: begin
					if (cmd_start) begin
						start_ff <= 1'b1;
						wait_ff <= 1'b0;
						kind_q <= irq ? pm_pkg::interrupt : pm_pkg::fetch;
						phase <= pm_pkg::pc;
						tick <= '0;
					end else if (wait_ff && irq) begin
						// interrupt wakes a halted machine
						wait_ff <= 1'b0;
						kind_q <= pm_pkg::interrupt;
						phase <= pm_pkg::pc;
						tick <= '0;
					end else if (cmd_stop) begin
						start_ff <= 1'b0;
						wait_ff <= 1'b0;
					end
				end
				pm_pkg::pc: begin
					if (tick == PC_LAST) begin
						phase <= pm_pkg::kc;
						tick <= '0;
					end else begin
						tick <= tick + 1'b1;
					end
				end
				pm_pkg::kc: begin
					if (tick != KC_LAST) begin
						tick <= tick + 1'b1;
					end else begin
						tick <= '0;
						// next cycle kind, steps first, then irq, then fetch
						if (cyc.more) begin
							kind_q <= pm_pkg::step;
							phase <= pm_pkg::pc;
						end else if (stop_req) begin
							phase <= pm_pkg::idle;
							stop_ff <= 1'b0;
							halt_ff <= 1'b0;
							if (halt_req)
								wait_ff <= 1'b1;
							else
								start_ff <= 1'b0;
						end else begin
							kind_q <= irq ? pm_pkg::interrupt : pm_pkg::fetch;
							phase <= pm_pkg::pc;
						end
					end
				end
				default: phase <= pm_pkg::idle;
			endcase
		end
	end

	// an interrupt is never taken in the middle of a multi-step instruction
	a_no_intr_mid_steps: assert property (@(posedge __clk) disable iff (!rst_n)
		cyc.kind == pm_pkg::interrupt |-> !cyc.more);

	// ack opens a full interrupt cycle that runs to its end
	a_ack_full_cycle: assert property (@(posedge __clk) disable iff (!rst_n)
		irq_ack |-> cyc.cyc_start ##(CYC_LEN - 1) cyc.cyc_end);

endmodule

`default_nettype wire

// ==== logic/pm_lg.sv ====
// P-M group counter
`timescale 1ns/1ps
`default_nettype none

module pm_lg (
	input wire __clk,
	input wire rst_n,
	input wire clear,
	output pm_pkg::lg_t lg,
	pm_cycle_if.cnt cyc
);

	// group preload field of the instruction
	pm_pkg::lg_t grp;

	assign grp = cyc.ir[8:7];

	// preload at fetch, one register further per step, wraps modulo 4
	always_ff @(posedge __clk or negedge rst_n) begin
		if (!rst_n) begin
			lg <= '0;
		end else if (clear) begin
			lg <= '0;
		end else if (cyc.cyc_start) begin
			case (cyc.kind)
				pm_pkg::fetch: lg <= grp;
				pm_pkg::step: lg <= pm_pkg::lg_t'(lg + 1'b1);
				default: lg <= lg;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== logic/pm_lk.sv ====
// P-M step counter
`timescale 1ns/1ps
`default_nettype none

module pm_lk (
	input wire __clk,
	input wire rst_n,
	input wire clear,
	output pm_pkg::lk_t lk,
	pm_cycle_if.cnt cyc
);

	// step count field of the instruction
	pm_pkg::lk_t steps;

	assign steps = cyc.ir[15:12];
	assign cyc.more = |lk;

	always_ff @(posedge __clk or negedge rst_n) begin
		if (!rst_n) begin
			lk <= '0;
		end else if (clear) begin
			lk <= '0;
		end else if (cyc.cyc_start) begin
			case (cyc.kind)
				pm_pkg::fetch: lk <= steps;
				pm_pkg::step: lk <= pm_pkg::lk_t'(lk - 1'b1);
				default: lk <= lk;
			endcase
		end
	end

	// sequencer only starts a step while steps remain
	a_no_underflow: assert property (@(posedge __clk) disable iff (!rst_n)
		cyc.cyc_start && cyc.kind == pm_pkg::step && !$past(clear) |-> lk != '0);

endmodule

`default_nettype wire

// ==== logic/pm_panel.sv ====
// P-M control panel
`timescale 1ns/1ps
`default_nettype none
`include "pm_defs.svh"

module pm_panel (
	input wire __clk,
	input wire rst_n,
	input wire [`PM_APB_AW-1:0] paddr,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire pm_pkg::word_t pwdata,
	output pm_pkg::word_t prdata,
	output logic pready,
	output logic pslverr,
	input wire run,
	input wire wait_st,
	input wire stop_pend,
	input wire pm_pkg::lg_t lg,
	input wire pm_pkg::lk_t lk,
	output logic cmd_start,
	output logic cmd_stop,
	output logic cmd_halt,
	output logic clear,
	pm_cycle_if.mon cyc
);

	localparam logic [`PM_APB_AW-1:0] A_CTRL = `PM_APB_AW'(0);
	localparam logic [`PM_APB_AW-1:0] A_IR = `PM_APB_AW'(1);
	localparam logic [`PM_APB_AW-1:0] A_FETCH = `PM_APB_AW'(2);
	localparam logic [`PM_APB_AW-1:0] A_INTR = `PM_APB_AW'(3);
	localparam logic [`PM_APB_AW-1:0] A_STEP = `PM_APB_AW'(4);
	localparam logic [`PM_APB_AW-1:0] A_LGLK = `PM_APB_AW'(5);

	pm_pkg::word_t ir_q;
	pm_pkg::cnt_t fetch_cnt;
	pm_pkg::cnt_t intr_cnt;
	pm_pkg::cnt_t step_cnt;
	logic access;
	logic mapped;
	logic ro;
	logic wr_ok;
	logic wr_ctrl;

	always_comb begin
		prdata = '0;
		mapped = 1'b1;
		ro = 1'b1;
		case (paddr)
			A_CTRL: begin
				prdata = {13'd0, stop_pend, wait_st, run};
				ro = 1'b0;
			end
			A_IR: begin
				prdata = ir_q;
				ro = 1'b0;
			end
			A_FETCH: prdata = fetch_cnt;
			A_INTR: prdata = intr_cnt;
			A_STEP: prdata = step_cnt;
			A_LGLK: prdata = {8'd0, lk, 2'd0, lg};
			default: mapped = 1'b0;
		endcase
	end

	// no wait states
	assign pready = 1'b1;
	assign access = psel & penable;
	assign pslverr = access & (~mapped | (pwrite & ro));
	assign wr_ok = access & pwrite & mapped & ~ro;
	assign wr_ctrl = wr_ok && (paddr == A_CTRL);

	// CTRL bits become single-clock commands
	assign cmd_start = wr_ctrl & pwdata[0];
	assign cmd_stop = wr_ctrl & pwdata[1];
	assign cmd_halt = wr_ctrl & pwdata[2];
	assign clear = wr_ctrl & pwdata[3];

	assign cyc.ir = ir_q;

	always_ff @(posedge __clk or negedge rst_n) begin
		if (!rst_n)
			ir_q <= '0;
		else if (wr_ok && paddr == A_IR)
			ir_q <= pwdata;
	end

	// cycle statistics, counted when a cycle completes
	always_ff @(posedge __clk or negedge rst_n) begin
		if (!rst_n) begin
			fetch_cnt <= '0;
			intr_cnt <= '0;
			step_cnt <= '0;
		end else if (clear) begin
			fetch_cnt <= '0;
			intr_cnt <= '0;
			step_cnt <= '0;
		end else if (cyc.cyc_end) begin
			case (cyc.kind)
				pm_pkg::fetch: fetch_cnt <= fetch_cnt + 1'b1;
				pm_pkg::interrupt: intr_cnt <= intr_cnt + 1'b1;
				pm_pkg::step: step_cnt <= step_cnt + 1'b1;
				default: step_cnt <= step_cnt;
			endcase
		end
	end

	// access phase always follows a setup phase
	a_apb_setup: assert property (@(posedge __clk) disable iff (!rst_n)
		penable |-> psel && $past(psel && !penable));

endmodule

`default_nettype wire

// ==== logic/pm_top.sv ====
// P-M cycle control top
`timescale 1ns/1ps
`default_nettype none
`include "pm_defs.svh"

module pm_top (
	input wire __clk,
	input wire rst_n,
	input wire [`PM_APB_AW-1:0] paddr,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire pm_pkg::word_t pwdata,
	output pm_pkg::word_t prdata,
	output logic pready,
	output logic pslverr,
	input wire irq,
	output logic run,
	output logic irq_ack
);

	logic wait_st;
	logic stop_pend;
	logic cmd_start;
	logic cmd_stop;
	logic cmd_halt;
	logic clear;
	pm_pkg::lg_t lg;
	pm_pkg::lk_t lk;

	pm_cycle_if cyc ();

	pm_cycle u_cycle (
		.__clk(__clk),
		.rst_n(rst_n),
		.irq(irq),
		.cmd_start(cmd_start),
		.cmd_stop(cmd_stop),
		.cmd_halt(cmd_halt),
		.run(run),
		.wait_st(wait_st),
		.stop_pend(stop_pend),
		.irq_ack(irq_ack),
		.cyc(cyc.seq)
	);

	pm_lg u_lg (
		.__clk(__clk),
		.rst_n(rst_n),
		.clear(clear),
		.lg(lg),
		.cyc(cyc.cnt)
	);

	pm_lk u_lk (
		.__clk(__clk),
		.rst_n(rst_n),
		.clear(clear),
		.lk(lk),
		.cyc(cyc.cnt)
	);

	pm_panel u_panel (
		.__clk(__clk),
		.rst_n(rst_n),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.run(run),
		.wait_st(wait_st),
		.stop_pend(stop_pend),
		.lg(lg),
		.lk(lk),
		.cmd_start(cmd_start),
		.cmd_stop(cmd_stop),
		.cmd_halt(cmd_halt),
		.clear(clear),
		.cyc(cyc.mon)
	);

endmodule

`default_nettype wire

// ==== sim/pm_tb.sv ====
// P-M cycle control testbench
`timescale 1ns/1ps
`default_nettype none
`include "pm_defs.svh"

module pm_tb;

	localparam int CYC_CLKS = `PM_KC_TICKS + `PM_PC_TICKS;
	// about 160 machine cycles over all tests, bus traffic included
	localparam int PLANNED_CYCLES = 160;
	localparam int LIMIT = 40 * PLANNED_CYCLES * CYC_CLKS;

	localparam logic [`PM_APB_AW-1:0] A_CTRL = `PM_APB_AW'(0);
	localparam logic [`PM_APB_AW-1:0] A_IR = `PM_APB_AW'(1);
	localparam logic [`PM_APB_AW-1:0] A_FETCH = `PM_APB_AW'(2);
	localparam logic [`PM_APB_AW-1:0] A_INTR = `PM_APB_AW'(3);
	localparam logic [`PM_APB_AW-1:0] A_STEP = `PM_APB_AW'(4);
	localparam logic [`PM_APB_AW-1:0] A_LGLK = `PM_APB_AW'(5);
	localparam logic [`PM_APB_AW-1:0] A_SPARE0 = `PM_APB_AW'(6);
	localparam logic [`PM_APB_AW-1:0] A_SPARE1 = `PM_APB_AW'(7);

	logic __clk;
	logic rst_n;
	logic [`PM_APB_AW-1:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	pm_pkg::word_t pwdata;
	pm_pkg::word_t prdata;
	logic pready;
	logic pslverr;
	logic irq;
	logic run;
	logic irq_ack;

	int cycles;
	int acks;
	int next_chk;
	string name_q[$];
	pm_pkg::word_t exp_q[$];
	pm_pkg::word_t act_q[$];
	event chk_ev;

	pm_top u_pm_top (
		.__clk(__clk),
		.rst_n(rst_n),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.irq(irq),
		.run(run),
		.irq_ack(irq_ack)
	);

	initial begin
		__clk = 1'b0;
		forever #20 __clk = ~__clk;
	end

	// acknowledges seen on the pin, only ever counted up
	initial acks = 0;
	always @(negedge __clk) begin
		if (rst_n && irq_ack)
			acks = acks + 1;
	end

	initial begin
		cycles = 0;
		while (cycles < LIMIT) begin
			@(posedge __clk);
			cycles++;
		end
		$display("timeout, the run did not finish within %0d clocks", LIMIT);
		$display("STATUS: FAIL");
		$fatal(1, "timeout");
	end

	// compare process, works through the queued results in order
	initial begin
		next_chk = 0;
		forever begin
			@(chk_ev);
			while (next_chk < exp_q.size()) begin
				assert (act_q[next_chk] == exp_q[next_chk]) else begin
					$display("ERR %s expected 0x%h got 0x%h", name_q[next_chk],
						exp_q[next_chk], act_q[next_chk]);
					$display("STATUS: FAIL");
					$fatal(1, "value mismatch");
				end
				next_chk++;
			end
		end
	end

	task automatic expect_val(input string name, input pm_pkg::word_t exp_v,
		input pm_pkg::word_t act_v);
		name_q.push_back(name);
		exp_q.push_back(exp_v);
		act_q.push_back(act_v);
		-> chk_ev;
	endtask

	// expected counters once the machine has stopped
	function automatic void ref_model(input pm_pkg::word_t ir, input pm_pkg::cnt_t fetches,
		input pm_pkg::cnt_t intr_acks, output pm_pkg::cnt_t steps,
		output pm_pkg::cnt_t intrs, output pm_pkg::lg_t lg, output pm_pkg::lk_t lk);
		pm_pkg::lk_t n;
		pm_pkg::lg_t grp;
		n = ir[15:12];
		grp = ir[8:7];
		// a stop waits for the last instruction to finish all its steps
		steps = pm_pkg::cnt_t'(32'(n) * 32'(fetches));
		intrs = intr_acks;
		lk = '0;
		if (fetches == '0)
			lg = '0;
		else
			lg = pm_pkg::lg_t'(grp + n);
	endfunction

	task automatic apb_xfer(input logic [`PM_APB_AW-1:0] addr, input logic wr,
		input pm_pkg::word_t wdata, output pm_pkg::word_t rdata, output logic err);
		@(posedge __clk);
		paddr <= addr;
		pwrite <= wr;
		pwdata <= wdata;
		psel <= 1'b1;
		penable <= 1'b0;
		@(posedge __clk);
		penable <= 1'b1;
		// response settled in the middle of the access clock
		@(negedge __clk);
		rdata = prdata;
		err = pslverr;
		expect_val("pready", 16'h0001, pm_pkg::word_t'(pready));
		@(posedge __clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic reg_write(input logic [`PM_APB_AW-1:0] addr, input pm_pkg::word_t data);
		pm_pkg::word_t rd;
		logic err;
		apb_xfer(addr, 1'b1, data, rd, err);
		expect_val("pslverr", 16'h0000, pm_pkg::word_t'(err));
	endtask

	task automatic reg_read(input logic [`PM_APB_AW-1:0] addr, output pm_pkg::word_t data);
		logic err;
		apb_xfer(addr, 1'b0, 16'h0000, data, err);
		expect_val("pslverr", 16'h0000, pm_pkg::word_t'(err));
	endtask

	task automatic bus_error(input logic [`PM_APB_AW-1:0] addr, input logic wr);
		pm_pkg::word_t rd;
		logic err;
		apb_xfer(addr, wr, 16'h000f, rd, err);
		expect_val("pslverr", 16'h0001, pm_pkg::word_t'(err));
	endtask

	task automatic load_and_start(output pm_pkg::word_t ir, input pm_pkg::lk_t n);
		pm_pkg::word_t rd;
		ir = pm_pkg::word_t'($urandom);
		ir[15:12] = n;
		ir[8:7] = pm_pkg::lg_t'($urandom_range(0, 3));
		reg_write(A_IR, ir);
		reg_read(A_IR, rd);
		expect_val("ir", ir, rd);
		reg_write(A_CTRL, 16'h0008);
		reg_write(A_CTRL, 16'h0001);
	endtask

	task automatic wait_stopped();
		@(negedge __clk);
		while (run)
			@(negedge __clk);
	endtask

	// returns at the falling edge inside the ack clock
	task automatic wait_ack();
		@(negedge __clk);
		while (!irq_ack)
			@(negedge __clk);
	endtask

	task automatic check_stopped(input pm_pkg::word_t ir, input int intr_acks);
		pm_pkg::word_t f;
		pm_pkg::word_t i;
		pm_pkg::word_t s;
		pm_pkg::word_t gk;
		pm_pkg::word_t later;
		pm_pkg::cnt_t es;
		pm_pkg::cnt_t ei;
		pm_pkg::lg_t eg;
		pm_pkg::lk_t ek;
		reg_read(A_FETCH, f);
		reg_read(A_INTR, i);
		reg_read(A_STEP, s);
		reg_read(A_LGLK, gk);
		assert (f != 16'h0000) else begin
			$display("no fetch cycle was counted while the machine was running");
			$display("STATUS: FAIL");
			$fatal(1, "no fetch");
		end
		ref_model(ir, f, pm_pkg::cnt_t'(intr_acks), es, ei, eg, ek);
		expect_val("intr_cnt", ei, i);
		expect_val("step_cnt", es, s);
		expect_val("lg", pm_pkg::word_t'(eg), pm_pkg::word_t'(gk[1:0]));
		expect_val("lk", pm_pkg::word_t'(ek), pm_pkg::word_t'(gk[7:4]));
		// counters stay put while stopped
		reg_read(A_FETCH, later);
		expect_val("fetch_cnt", f, later);
		reg_read(A_INTR, later);
		expect_val("intr_cnt", i, later);
		reg_read(A_STEP, later);
		expect_val("step_cnt", s, later);
		reg_read(A_LGLK, later);
		expect_val("lglk", gk, later);
	endtask

	initial begin
		pm_pkg::word_t ir;
		pm_pkg::word_t rd;
		pm_pkg::word_t f_halt;
		pm_pkg::word_t f_now;
		pm_pkg::word_t snap[6];
		int base;
		void'($urandom(32'hc2df_d9c8));
		rst_n <= 1'b0;
		paddr <= '0;
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
		pwdata <= '0;
		irq <= 1'b0;
		repeat (2) @(posedge __clk);
		rst_n <= 1'b1;

		// reset state
		@(negedge __clk);
		expect_val("run", 16'h0000, pm_pkg::word_t'(run));
		expect_val("irq_ack", 16'h0000, pm_pkg::word_t'(irq_ack));
		for (int a = 0; a < 6; a++) begin
			reg_read(`PM_APB_AW'(a), rd);
			expect_val($sformatf("reg %0d", a), 16'h0000, rd);
		end

		// random programs stopped after a random run
		for (int r = 0; r < 2; r++) begin
			base = acks;
			load_and_start(ir, pm_pkg::lk_t'($urandom_range(1, 6)));
			repeat ($urandom_range(20, 60)) @(posedge __clk);
			reg_write(A_CTRL, 16'h0002);
			wait_stopped();
			check_stopped(ir, acks - base);
		end

		// interrupts taken only at instruction boundaries
		base = acks;
		load_and_start(ir, pm_pkg::lk_t'($urandom_range(2, 5)));
		for (int k = 0; k < 3; k++) begin
			repeat ($urandom_range(5, 30)) @(posedge __clk);
			irq <= 1'b1;
			wait_ack();
			@(posedge __clk);
			irq <= 1'b0;
			reg_read(A_LGLK, rd);
			expect_val("lk at ack", 16'h0000, pm_pkg::word_t'(rd[7:4]));
		end
		reg_write(A_CTRL, 16'h0002);
		wait_stopped();
		check_stopped(ir, acks - base);

		// halt, then an interrupt wakes the machine
		base = acks;
		load_and_start(ir, pm_pkg::lk_t'($urandom_range(1, 4)));
		repeat ($urandom_range(10, 40)) @(posedge __clk);
		reg_write(A_CTRL, 16'h0004);
		wait_stopped();
		reg_read(A_CTRL, rd);
		expect_val("ctrl", 16'h0002, rd);
		reg_read(A_FETCH, f_halt);
		irq <= 1'b1;
		wait_ack();
		expect_val("run", 16'h0001, pm_pkg::word_t'(run));
		@(posedge __clk);
		irq <= 1'b0;
		reg_read(A_CTRL, rd);
		expect_val("ctrl", 16'h0001, rd);
		repeat (4 * CYC_CLKS) @(posedge __clk);
		reg_read(A_FETCH, f_now);
		assert (f_now > f_halt) else begin
			$display("fetch count did not advance after the interrupt woke the machine");
			$display("STATUS: FAIL");
			$fatal(1, "no fetch after wake");
		end
		reg_write(A_CTRL, 16'h0002);
		wait_stopped();
		check_stopped(ir, acks - base);

		// bus errors leave every register alone
		for (int a = 0; a < 6; a++)
			reg_read(`PM_APB_AW'(a), snap[a]);
		bus_error(A_SPARE0, 1'b0);
		bus_error(A_SPARE1, 1'b0);
		bus_error(A_SPARE0, 1'b1);
		bus_error(A_FETCH, 1'b1);
		for (int a = 0; a < 6; a++) begin
			reg_read(`PM_APB_AW'(a), rd);
			expect_val($sformatf("reg %0d", a), snap[a], rd);
		end

		@(negedge __clk);
		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== pm_top.f ====
+incdir+logic
logic/pm_pkg.sv
logic/pm_cycle_if.sv
logic/pm_cycle.sv
logic/pm_lg.sv
logic/pm_lk.sv
logic/pm_panel.sv
logic/pm_top.sv
sim/pm_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= pm_tb
BUILD ?= build
LOG ?= $(BUILD)/run.log
FLIST ?= pm_top.f

SRCS := $(filter-out +%,$(shell cat $(FLIST)))
HDRS := $(wildcard logic/*.svh)
BIN := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(FLIST) $(SRCS) $(HDRS)
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) \
		--Mdir $(BUILD) -f $(FLIST)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD)
